/* Bender.yml */
package:
  name: icache

sources:
  - include_dirs:
      - .
    files:
      - icache_pkg.sv
      - icache_data_array.sv
      - icache_tag_array.sv
      - icache_refill.sv
      - icache_ctrl.sv
      - icache_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_mem_model.sv
      - tb_icache.sv

/* icache.f */
+incdir+.
icache_pkg.sv
icache_data_array.sv
icache_tag_array.sv
icache_refill.sv
icache_ctrl.sv
icache_top.sv
tb_mem_model.sv
tb_icache.sv

/* icache_ctrl.sv */
`timescale 1ns/10ps
`include "icache_settings.svh"

module icache_ctrl (
    input  logic                       clk,
    input  logic                       nrst,
    input  icache_pkg::axi_ar_t        s_ar,
    input  logic                       s_arvalid,
    output logic                       s_arready,
    output icache_pkg::axi_r_t         s_r,
    output logic                       s_rvalid,
    input  logic                       s_rready,
    output logic [`ICACHE_IDX_W-1:0]   arr_index,
    output logic [`ICACHE_WSEL_W-1:0]  arr_wsel,
    input  logic [`ICACHE_TAG_W-1:0]   rd_tag,
    input  logic                       rd_valid,
    input  logic [`ICACHE_WORD_W-1:0]  rd_word,
    output logic                       install,
    output logic [`ICACHE_TAG_W-1:0]   inst_tag,
    output logic                       refill_start,
    output logic [31:0]                refill_base,
    input  logic                       refill_done,
    input  logic                       refill_err
);

    icache_pkg::ctrl_state_t state, state_d;
    logic [31:0]        addr_q;
    logic               rd_ok;
    logic               hit;
    logic               ar_fire;
    icache_pkg::axi_r_t r_q;

    assign ar_fire = s_arvalid && s_arready;

    // array outputs are valid in the second LOOKUP cycle
    assign hit = rd_valid && (rd_tag == addr_q[`ICACHE_TAG_LSB +: `ICACHE_TAG_W]);

    assign arr_index    = addr_q[`ICACHE_IDX_LSB +: `ICACHE_IDX_W];
    assign arr_wsel     = addr_q[`ICACHE_WSEL_LSB +: `ICACHE_WSEL_W];
    assign inst_tag     = addr_q[`ICACHE_TAG_LSB +: `ICACHE_TAG_W];
    assign refill_base  = {addr_q[31:`ICACHE_IDX_LSB], `ICACHE_IDX_LSB'(0)};
    assign refill_start = (state == icache_pkg::LOOKUP) && rd_ok && !hit;
    assign install      = (state == icache_pkg::INSTALL);
    assign s_rvalid     = (state == icache_pkg::RESPOND);
    assign s_r          = r_q;

    always_comb
    begin
        state_d = state;
        case (state)
            icache_pkg::IDLE:
                if (ar_fire)
                    state_d = icache_pkg::LOOKUP;
            icache_pkg::LOOKUP:
                if (rd_ok)
                    state_d = hit ? icache_pkg::RESPOND : icache_pkg::REFILL;
            icache_pkg::REFILL:
                if (refill_done)
                    state_d = refill_err ? icache_pkg::RESPOND : icache_pkg::INSTALL;
            icache_pkg::INSTALL:
                state_d = icache_pkg::LOOKUP;
            icache_pkg::RESPOND:
                if (s_rready)
                    state_d = icache_pkg::IDLE;
            default:
                state_d = icache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            state     <= icache_pkg::IDLE;
            s_arready <= 1'b0;
            rd_ok     <= 1'b0;
        end
        else
        begin
            state     <= state_d;
            s_arready <= (state_d == icache_pkg::IDLE);
            rd_ok     <= (state == icache_pkg::LOOKUP) && !rd_ok;
        end
    end

    // fetch address and response payload
    always_ff @(posedge clk)
    begin
        if (ar_fire)
            addr_q <= s_ar.addr;
        if (state == icache_pkg::LOOKUP && rd_ok && hit)
            r_q <= '{data: rd_word, resp: `AXI_RESP_OKAY};
        else if (state == icache_pkg::REFILL && refill_done && refill_err)
            r_q <= '{data: 32'h0, resp: `AXI_RESP_SLVERR};
    end

endmodule

/* icache_data_array.sv */
`timescale 1ns/10ps
`include "icache_settings.svh"

module icache_data_array (
    input  logic                       clk,
    input  logic                       nrst,
    input  logic [`ICACHE_IDX_W-1:0]   rd_index,
    input  logic [`ICACHE_WSEL_W-1:0]  rd_wsel,
    output logic [`ICACHE_WORD_W-1:0]  rd_word,
    input  logic                       wr_en,
    input  logic [`ICACHE_IDX_W-1:0]   wr_index,
    input  logic [`ICACHE_LINE_W-1:0]  wr_line
);

    logic [`ICACHE_LINE_W-1:0] mem [0:`ICACHE_SETS-1];
    logic [`ICACHE_LINE_W-1:0] rd_line;

    assign rd_line = mem[rd_index];

    // registered word read, old contents on a same-edge refill
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            rd_word <= '0;
        end
        else
        begin
            rd_word <= rd_line[rd_wsel*`ICACHE_WORD_W +: `ICACHE_WORD_W];
        end
    end

    // whole line replaced on refill
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_index] <= wr_line;
        end
    end

endmodule

/* icache_pkg.sv */
package icache_pkg;

    // read address channel payload
    typedef struct packed
    {
        logic [31:0] addr;
        logic [2:0]  prot;
    } axi_ar_t;

    // read data channel payload
    typedef struct packed
    {
        logic [31:0] data;
        logic [1:0]  resp;
    } axi_r_t;

    // fetch-side controller
    typedef enum logic [2:0]
    {
        IDLE,
        LOOKUP,
        REFILL,
        INSTALL,
        RESPOND
    } ctrl_state_t;

    // line refill engine
    typedef enum logic [1:0]
    {
        R_IDLE,
        R_ADDR,
        R_DATA,
        R_DONE
    } refill_state_t;

endpackage

/* icache_refill.sv */
`timescale 1ns/10ps
`include "icache_settings.svh"

module icache_refill (
    input  logic                       clk,
    input  logic                       nrst,
    input  logic                       start,
    input  logic [31:0]                base_addr,
    output logic                       done,
    output logic                       err,
    output logic [`ICACHE_LINE_W-1:0]  line,
    output icache_pkg::axi_ar_t        m_ar,
    output logic                       m_arvalid,
    input  logic                       m_arready,
    input  icache_pkg::axi_r_t         m_r,
    input  logic                       m_rvalid,
    output logic                       m_rready
);

    icache_pkg::refill_state_t state;
    logic [`ICACHE_WSEL_W-1:0] beat;
    logic [31:0]               base_q;

    assign m_arvalid = (state == icache_pkg::R_ADDR);
    assign m_rready  = (state == icache_pkg::R_DATA);
    assign done      = (state == icache_pkg::R_DONE);

    // one word per read, beat picks the word inside the line
    assign m_ar.addr = {base_q[31:`ICACHE_IDX_LSB], beat, 2'b00};
    assign m_ar.prot = `AXI_PROT_INSN;

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            state <= icache_pkg::R_IDLE;
            beat  <= '0;
            err   <= 1'b0;
        end
        else
        begin
            case (state)
                icache_pkg::R_IDLE:
                begin
                    if (start)
                    begin
                        beat  <= '0;
                        err   <= 1'b0;
                        state <= icache_pkg::R_ADDR;
                    end
                end
                icache_pkg::R_ADDR:
                begin
                    if (m_arready)
                        state <= icache_pkg::R_DATA;
                end
                icache_pkg::R_DATA:
                begin
                    if (m_rvalid)
                    begin
                        if (m_r.resp != `AXI_RESP_OKAY)
                            err <= 1'b1;
                        if (beat == `ICACHE_WSEL_W'(`ICACHE_WORDS - 1))
                        begin
                            state <= icache_pkg::R_DONE;
                        end
                        else
                        begin
                            beat  <= beat + 1'b1;
                            state <= icache_pkg::R_ADDR;
                        end
                    end
                end
                default:
                    state <= icache_pkg::R_IDLE;
            endcase
        end
    end

    // line buffer and base address
    always_ff @(posedge clk)
    begin
        if (state == icache_pkg::R_IDLE && start)
            base_q <= base_addr;
        if (state == icache_pkg::R_DATA && m_rvalid)
            line[beat*`ICACHE_WORD_W +: `ICACHE_WORD_W] <= m_r.data;
    end

endmodule

/* icache_settings.svh */
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// cache geometry, fixed by the 512-bit line
`define ICACHE_SETS     64
`define ICACHE_LINE_W   512
`define ICACHE_WORDS    16
`define ICACHE_WORD_W   32

// address split: tag [31:12], index [11:6], word [5:2]
`define ICACHE_TAG_W    20
`define ICACHE_IDX_W    6
`define ICACHE_WSEL_W   4
`define ICACHE_TAG_LSB  12
`define ICACHE_IDX_LSB  6
`define ICACHE_WSEL_LSB 2

// AXI response codes
`define AXI_RESP_OKAY   2'b00
`define AXI_RESP_SLVERR 2'b10

// instruction, secure, unprivileged
`define AXI_PROT_INSN   3'b100

`endif

/* icache_tag_array.sv */
`timescale 1ns/10ps
`include "icache_settings.svh"

module icache_tag_array (
    input  logic                      clk,
    input  logic                      nrst,
    input  logic [`ICACHE_IDX_W-1:0]  rd_index,
    output logic [`ICACHE_TAG_W-1:0]  rd_tag,
    output logic                      rd_valid,
    input  logic                      wr_en,
    input  logic [`ICACHE_IDX_W-1:0]  wr_index,
    input  logic [`ICACHE_TAG_W-1:0]  wr_tag,
    input  logic                      flush
);

    logic [`ICACHE_TAG_W-1:0] tags [0:`ICACHE_SETS-1];
    logic [`ICACHE_SETS-1:0]  valid;

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            rd_tag   <= '0;
            rd_valid <= 1'b0;
            valid    <= '0;
        end
        else
        begin
            rd_tag   <= tags[rd_index];
            rd_valid <= valid[rd_index];
            // flush beats a coinciding install
            if (flush)
                valid <= '0;
            else if (wr_en)
                valid[wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            tags[wr_index] <= wr_tag;
        end
    end

endmodule

/* icache_top.sv */
`timescale 1ns/10ps
`include "icache_settings.svh"

module icache_top (
    input  logic                clk,
    input  logic                nrst,
    input  logic                flush,
    input  icache_pkg::axi_ar_t s_ar,
    input  logic                s_arvalid,
    output logic                s_arready,
    output icache_pkg::axi_r_t  s_r,
    output logic                s_rvalid,
    input  logic                s_rready,
    output icache_pkg::axi_ar_t m_ar,
    output logic                m_arvalid,
    input  logic                m_arready,
    input  icache_pkg::axi_r_t  m_r,
    input  logic                m_rvalid,
    output logic                m_rready
);

    logic [`ICACHE_IDX_W-1:0]  arr_index;
    logic [`ICACHE_WSEL_W-1:0] arr_wsel;
    logic [`ICACHE_TAG_W-1:0]  rd_tag;
    logic                      rd_valid;
    logic [`ICACHE_WORD_W-1:0] rd_word;
    logic                      install;
    logic [`ICACHE_TAG_W-1:0]  inst_tag;
    logic                      refill_start;
    logic [31:0]               refill_base;
    logic                      refill_done;
    logic                      refill_err;
    logic [`ICACHE_LINE_W-1:0] refill_line;

    icache_ctrl i_ctrl (
        .clk, .nrst,
        .s_ar, .s_arvalid, .s_arready,
        .s_r, .s_rvalid, .s_rready,
        .arr_index, .arr_wsel,
        .rd_tag, .rd_valid, .rd_word,
        .install, .inst_tag,
        .refill_start, .refill_base, .refill_done, .refill_err
    );

    // lookup and install share one index
    icache_tag_array i_tag_array (
        .clk, .nrst,
        .rd_index (arr_index), .rd_tag, .rd_valid,
        .wr_en (install), .wr_index (arr_index), .wr_tag (inst_tag),
        .flush
    );

    icache_data_array i_data_array (
        .clk, .nrst,
        .rd_index (arr_index), .rd_wsel (arr_wsel), .rd_word,
        .wr_en (install), .wr_index (arr_index), .wr_line (refill_line)
    );

    icache_refill i_refill (
        .clk, .nrst,
        .start (refill_start), .base_addr (refill_base),
        .done (refill_done), .err (refill_err), .line (refill_line),
        .m_ar, .m_arvalid, .m_arready,
        .m_r, .m_rvalid, .m_rready
    );

endmodule

/* tb_icache.sv */
`timescale 1ns/10ps
`include "icache_settings.svh"

module tb_icache;

    localparam logic [31:0] data_pattern = 32'h5A5A_C3C3;
    localparam int          n_random     = 24;
    localparam int          n_fetches    = 4 + n_random + 8 + 2 + 3;

    logic                clk;
    logic                nrst;
    logic                flush;
    icache_pkg::axi_ar_t s_ar;
    logic                s_arvalid;
    logic                s_arready;
    icache_pkg::axi_r_t  s_r;
    logic                s_rvalid;
    logic                s_rready;
    icache_pkg::axi_ar_t m_ar;
    logic                m_arvalid;
    logic                m_arready;
    icache_pkg::axi_r_t  m_r;
    logic                m_rvalid;
    logic                m_rready;
    logic [2:0]          mem_lat;
    int unsigned         mem_reads;

    // reference cache contents and the expectation for the fetch in flight
    logic [`ICACHE_TAG_W-1:0] ref_tag [0:`ICACHE_SETS-1];
    logic [`ICACHE_SETS-1:0]  ref_valid;
    logic [31:0]              exp_data;
    logic [31:0]              exp_base;
    logic                     exp_err;
    logic                     exp_hit;
    int unsigned              reads_at_start;
    logic [15:0]              stim_lfsr;
    logic [15:0]              mem_lfsr;

    logic [`ICACHE_IDX_W-1:0] ar_idx;
    logic                     ar_hit;
    logic                     ar_fire;
    logic                     r_fire;
    logic                     m_ar_fire;
    int unsigned              beat_idx;

    assign ar_idx    = s_ar.addr[`ICACHE_IDX_LSB +: `ICACHE_IDX_W];
    assign ar_hit    = ref_valid[ar_idx]
                       && (ref_tag[ar_idx] == s_ar.addr[`ICACHE_TAG_LSB +: `ICACHE_TAG_W]);
    assign ar_fire   = s_arvalid && s_arready;
    assign r_fire    = s_rvalid && s_rready;
    assign m_ar_fire = m_arvalid && m_arready;
    assign beat_idx  = mem_reads - reads_at_start;

    always #5 clk = ~clk;

    icache_top i_dut (
        .clk, .nrst, .flush,
        .s_ar, .s_arvalid, .s_arready,
        .s_r, .s_rvalid, .s_rready,
        .m_ar, .m_arvalid, .m_arready,
        .m_r, .m_rvalid, .m_rready
    );

    tb_mem_model i_mem (
        .clk, .nrst,
        .ar (m_ar), .arvalid (m_arvalid), .arready (m_arready),
        .r (m_r), .rvalid (m_rvalid), .rready (m_rready),
        .lat (mem_lat), .reads (mem_reads)
    );

    task automatic abort_run(input string line);
        $display("%s", line);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] st);
        return {st[14:0], st[15] ^ st[13] ^ st[12] ^ st[10]};
    endfunction

    task automatic draw_bits(inout logic [15:0] st, input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            st = lfsr_step(st);
            v  = {v[30:0], st[0]};
        end
    endtask

    always @(posedge clk)
    begin
        logic [31:0] v;
        draw_bits(mem_lfsr, 3, v);
        mem_lat <= v[2:0];
    end

    fetch_data_ok: assert property (@(posedge clk) disable iff (!nrst)
        r_fire |-> s_r.data == (exp_err ? 32'h0 : exp_data))
        else abort_run($sformatf("FAIL @ %0t: fetch data %h, expected %h",
                                 $time, $sampled(s_r.data), exp_err ? 32'h0 : exp_data));

    resp_code_ok: assert property (@(posedge clk) disable iff (!nrst)
        r_fire |-> s_r.resp == (exp_err ? `AXI_RESP_SLVERR : `AXI_RESP_OKAY))
        else abort_run($sformatf("FAIL @ %0t: response code %0d, expected error %0d",
                                 $time, $sampled(s_r.resp), exp_err));

    // 16 memory reads on a miss and none on a hit
    miss_read_count: assert property (@(posedge clk) disable iff (!nrst)
        r_fire |-> beat_idx == (exp_hit ? 0 : 16))
        else abort_run($sformatf("FAIL @ %0t: %0d memory reads for the fetch, expected %0d",
                                 $time, $sampled(beat_idx), exp_hit ? 0 : 16));

    refill_addr_seq: assert property (@(posedge clk) disable iff (!nrst)
        m_ar_fire |-> !exp_hit && beat_idx < 16 && m_ar.prot == `AXI_PROT_INSN
                      && m_ar.addr == exp_base + (beat_idx << 2))
        else abort_run($sformatf("FAIL @ %0t: memory read %h prot %b, expected %h",
                                 $time, $sampled(m_ar.addr), $sampled(m_ar.prot),
                                 exp_base + (beat_idx << 2)));

    hit_latency: assert property (@(posedge clk) disable iff (!nrst)
        ar_fire && ar_hit |-> ##1 !s_rvalid ##1 !s_rvalid ##1 s_rvalid)
        else abort_run($sformatf("FAIL @ %0t: hit response not two cycles after AR", $time));

    r_held_stable: assert property (@(posedge clk) disable iff (!nrst)
        s_rvalid && !s_rready |=> s_rvalid && $stable(s_r))
        else abort_run($sformatf("FAIL @ %0t: response changed under back-pressure", $time));

    no_ar_while_r: assert property (@(posedge clk) disable iff (!nrst)
        s_rvalid |-> !s_arready)
        else abort_run($sformatf("FAIL @ %0t: AR accepted while a response waits", $time));

    task automatic fetch(input logic [31:0] addr);
        logic [31:0]              stall;
        logic [`ICACHE_IDX_W-1:0] idx;
        idx       = addr[`ICACHE_IDX_LSB +: `ICACHE_IDX_W];
        s_ar      <= '{addr: addr, prot: `AXI_PROT_INSN};
        s_arvalid <= 1'b1;
        do
        begin
            @(posedge clk);
        end
        while (!s_arready);
        s_arvalid      <= 1'b0;
        exp_data       <= {addr[31:2], 2'b00} ^ data_pattern;
        exp_base       <= {addr[31:6], 6'b0};
        exp_err        <= (addr[31:28] == 4'hF);
        exp_hit        <= ar_hit;
        reads_at_start <= mem_reads;
        // random stalls until the response is taken
        do
        begin
            draw_bits(stim_lfsr, 1, stall);
            s_rready <= stall[0];
            @(posedge clk);
        end
        while (!(s_rvalid && s_rready));
        s_rready <= 1'b0;
        if (addr[31:28] != 4'hF)
        begin
            ref_valid[idx] <= 1'b1;
            ref_tag[idx]   <= addr[`ICACHE_TAG_LSB +: `ICACHE_TAG_W];
        end
    endtask

    task automatic flush_cache();
        flush <= 1'b1;
        @(posedge clk);
        flush     <= 1'b0;
        ref_valid <= '0;
    endtask

    initial
    begin
        logic [31:0] v;
        clk            = 1'b0;
        nrst           = 1'b0;
        flush          = 1'b0;
        s_ar           = '0;
        s_arvalid      = 1'b0;
        s_rready       = 1'b0;
        mem_lat        = '0;
        ref_valid      = '0;
        exp_data       = '0;
        exp_base       = '0;
        exp_err        = 1'b0;
        exp_hit        = 1'b0;
        reads_at_start = 0;
        stim_lfsr      = 16'd36906;
        mem_lfsr       = 16'd36906;
        repeat (8) @(posedge clk);
        nrst <= 1'b1;
        @(posedge clk);
        // line fill, then hits on other words of the line
        fetch(32'h0000_1040);
        fetch(32'h0000_1044);
        fetch(32'h0000_107c);
        fetch(32'h0000_1043);
        // four tags over eight sets, so lines get reused and evicted
        repeat (n_random)
        begin
            draw_bits(stim_lfsr, 11, v);
            fetch(32'h0010_0000 | {18'b0, v[10:9], 3'b0, v[8:6], v[5:2], v[1:0]});
        end
        // same set, different tags
        repeat (4)
        begin
            fetch(32'h0000_2080);
            fetch(32'h0000_3084);
        end
        fetch(32'hf000_0100);
        fetch(32'hf000_0100);
        fetch(32'h0000_5600);
        fetch(32'h0000_5608);
        flush_cache();
        fetch(32'h0000_5604);
        repeat (4) @(posedge clk);
        $display(">>> PASS");
        $finish;
    end

    // 200 cycles per fetch
    initial
    begin
        #(n_fetches * 200 * 10);
        abort_run("timeout: the fetch sequence did not finish in time");
    end

endmodule

/* tb_mem_model.sv */
`timescale 1ns/10ps
`include "icache_settings.svh"

module tb_mem_model (
    input  logic                clk,
    input  logic                nrst,
    input  icache_pkg::axi_ar_t ar,
    input  logic                arvalid,
    output logic                arready,
    output icache_pkg::axi_r_t  r,
    output logic                rvalid,
    input  logic                rready,
    input  logic [2:0]          lat,
    output int unsigned         reads
);

    localparam logic [31:0] data_pattern = 32'h5A5A_C3C3;

    logic        busy;
    logic [2:0]  wait_cnt;
    logic [31:0] addr_q;

    // one read in flight at a time
    assign arready = !busy;

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            busy     <= 1'b0;
            rvalid   <= 1'b0;
            wait_cnt <= '0;
            addr_q   <= '0;
            r        <= '0;
            reads    <= 0;
        end
        else if (arvalid && arready)
        begin
            busy     <= 1'b1;
            addr_q   <= ar.addr;
            wait_cnt <= lat;
            reads    <= reads + 1;
        end
        else if (busy && !rvalid)
        begin
            if (wait_cnt == '0)
            begin
                rvalid <= 1'b1;
                r.data <= {addr_q[31:2], 2'b00} ^ data_pattern;
                // top sixteenth of the address map is the fault region
                r.resp <= (addr_q[31:28] == 4'hF) ? `AXI_RESP_SLVERR : `AXI_RESP_OKAY;
            end
            else
            begin
                wait_cnt <= wait_cnt - 1'b1;
            end
        end
        else if (rvalid && rready)
        begin
            rvalid <= 1'b0;
            busy   <= 1'b0;
        end
    end

endmodule
